/* source/vga_pkg.sv */
/*
 * Shared definitions for the VGA game pipeline: coordinate and colour
 * types, the missile state enum, default 1024x768 geometry, colours,
 * sprite sizes, per-frame steps and the player row helper.
 */
`default_nettype none

package vga_pkg;

  typedef logic [10:0] count_t;
  typedef logic [11:0] rgb_t;

  typedef enum logic [0:0] {
    MISSILE_IDLE,
    MISSILE_FLYING
  } missile_state_t;

  // 1024x768 at 65 MHz
  localparam int H_ACTIVE_DEF = 1024;
  localparam int H_FRONT_DEF  = 24;
  localparam int H_SYNC_DEF   = 136;
  localparam int H_BACK_DEF   = 160;
  localparam int V_ACTIVE_DEF = 768;
  localparam int V_FRONT_DEF  = 3;
  localparam int V_SYNC_DEF   = 6;
  localparam int V_BACK_DEF   = 29;

  localparam rgb_t BG_COLOR      = 12'h226;
  localparam rgb_t BORDER_COLOR  = 12'hfff;
  localparam rgb_t PLAYER_COLOR  = 12'h0f0;
  localparam rgb_t MISSILE_COLOR = 12'hf40;

  localparam count_t PLAYER_W     = 11'd8;
  localparam count_t PLAYER_H     = 11'd4;
  localparam count_t MISSILE_W    = 11'd2;
  localparam count_t MISSILE_H    = 11'd3;
  localparam count_t PLAYER_STEP  = 11'd2;
  localparam count_t MISSILE_STEP = 11'd4;

  // top row of the player band, two lines above the bottom of the screen
  function automatic count_t player_top(int v_active);
    return count_t'(v_active) - PLAYER_H - count_t'(2);
  endfunction

endpackage

`default_nettype wire

/* source/vga_if.sv */
/*
 * Timing and colour bundle passed between pipeline stages.
 * src is the driving stage, snk the reading stage.
 */
`timescale 1ns/100ps
`default_nettype none

interface vga_if;

  vga_pkg::count_t hcount;
  vga_pkg::count_t vcount;
  logic            hsync;
  logic            vsync;
  logic            hblnk;
  logic            vblnk;
  vga_pkg::rgb_t   rgb;

  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

`default_nettype wire

/* source/vga_timing.sv */
/*
 * VGA timing generator: pixel and line counters with registered
 * sync and blanking, all aligned to the counter values.
 */
`timescale 1ns/100ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = vga_pkg::H_ACTIVE_DEF,
  parameter int H_FRONT  = vga_pkg::H_FRONT_DEF,
  parameter int H_SYNC   = vga_pkg::H_SYNC_DEF,
  parameter int H_BACK   = vga_pkg::H_BACK_DEF,
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE_DEF,
  parameter int V_FRONT  = vga_pkg::V_FRONT_DEF,
  parameter int V_SYNC   = vga_pkg::V_SYNC_DEF,
  parameter int V_BACK   = vga_pkg::V_BACK_DEF
) (
  input  logic  pclk,
  input  logic  reset,
  vga_if.src    tim
);

  localparam vga_pkg::count_t H_LAST  = vga_pkg::count_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
  localparam vga_pkg::count_t V_LAST  = vga_pkg::count_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
  localparam vga_pkg::count_t H_VIS   = vga_pkg::count_t'(H_ACTIVE);
  localparam vga_pkg::count_t V_VIS   = vga_pkg::count_t'(V_ACTIVE);
  localparam vga_pkg::count_t HS_BEG  = vga_pkg::count_t'(H_ACTIVE + H_FRONT);
  localparam vga_pkg::count_t HS_END  = vga_pkg::count_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam vga_pkg::count_t VS_BEG  = vga_pkg::count_t'(V_ACTIVE + V_FRONT);
  localparam vga_pkg::count_t VS_END  = vga_pkg::count_t'(V_ACTIVE + V_FRONT + V_SYNC);

  vga_pkg::count_t h_next;
  vga_pkg::count_t v_next;

  // next counter values, sync and blank are decoded from these so
  // the registered flags line up with the registered counts
  always_comb begin
    h_next = tim.hcount + vga_pkg::count_t'(1);
    v_next = tim.vcount;
    if (tim.hcount == H_LAST) begin
      h_next = '0;
      v_next = (tim.vcount == V_LAST) ? '0 : tim.vcount + vga_pkg::count_t'(1);
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      tim.hcount <= '0;
      tim.vcount <= '0;
      tim.hsync  <= 1'b0;
      tim.vsync  <= 1'b0;
      tim.hblnk  <= 1'b0;
      tim.vblnk  <= 1'b0;
    end else begin
      tim.hcount <= h_next;
      tim.vcount <= v_next;
      tim.hsync  <= (h_next >= HS_BEG) && (h_next < HS_END);
      tim.vsync  <= (v_next >= VS_BEG) && (v_next < VS_END);
      tim.hblnk  <= (h_next >= H_VIS);
      tim.vblnk  <= (v_next >= V_VIS);
    end
  end

  // no picture yet, the drawing stages paint over black
  assign tim.rgb = '0;

endmodule

`default_nettype wire

/* source/game_ctl.sv */
/*
 * Game control: button synchronizers, frame tick detection,
 * player x position and the missile state machine.
 */
`timescale 1ns/100ps
`default_nettype none

module game_ctl #(
  parameter int H_ACTIVE = vga_pkg::H_ACTIVE_DEF,
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE_DEF
) (
  input  logic            pclk,
  input  logic            reset,
  input  logic            left,
  input  logic            right,
  input  logic            fire,
  vga_if.snk              tim,
  output vga_pkg::count_t xpos,
  output vga_pkg::count_t xpos_missile,
  output vga_pkg::count_t missile_y,
  output logic            missile_on
);

  localparam vga_pkg::count_t X_MAX     = vga_pkg::count_t'(H_ACTIVE) - vga_pkg::PLAYER_W;
  localparam vga_pkg::count_t X_START   = X_MAX >> 1;
  localparam vga_pkg::count_t V_VIS     = vga_pkg::count_t'(V_ACTIVE);
  localparam vga_pkg::count_t MISSILE_Y0 = vga_pkg::player_top(V_ACTIVE) - vga_pkg::MISSILE_H;
  // offset from player left edge to missile left edge
  localparam vga_pkg::count_t X_CENTRE  = (vga_pkg::PLAYER_W >> 1) - (vga_pkg::MISSILE_W >> 1);

  logic [2:0] btn_meta;
  logic [2:0] btn_sync;
  logic       left_s;
  logic       right_s;
  logic       fire_s;
  logic       frame_tick;

  vga_pkg::missile_state_t state;

  // two-flop synchronizer for left, right and fire
  always_ff @(posedge pclk) begin
    if (reset) begin
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      btn_meta <= {left, right, fire};
      btn_sync <= btn_meta;
    end
  end

  assign left_s  = btn_sync[2];
  assign right_s = btn_sync[1];
  assign fire_s  = btn_sync[0];

  // first pixel of the first blanking line
  assign frame_tick = tim.vblnk && (tim.hcount == '0) && (tim.vcount == V_VIS);

  // both buttons held cancel each other
  always_ff @(posedge pclk) begin
    if (reset) begin
      xpos <= X_START;
    end else if (frame_tick) begin
      if (left_s && !right_s) begin
        xpos <= (xpos < vga_pkg::PLAYER_STEP) ? '0 : xpos - vga_pkg::PLAYER_STEP;
      end else if (right_s && !left_s) begin
        xpos <= (xpos > X_MAX - vga_pkg::PLAYER_STEP) ? X_MAX : xpos + vga_pkg::PLAYER_STEP;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      state <= vga_pkg::MISSILE_IDLE;
    end else if (frame_tick) begin
      case (state)
        vga_pkg::MISSILE_IDLE: begin
          if (fire_s) begin
            state <= vga_pkg::MISSILE_FLYING;
          end
        end
        vga_pkg::MISSILE_FLYING: begin
          if (missile_y < vga_pkg::MISSILE_STEP) begin
            state <= vga_pkg::MISSILE_IDLE;
          end
        end
        default: state <= vga_pkg::MISSILE_IDLE;
      endcase
    end
  end

  // launch uses the player position held during the frame just shown
  always_ff @(posedge pclk) begin
    if (frame_tick) begin
      if (state == vga_pkg::MISSILE_IDLE && fire_s) begin
        missile_y    <= MISSILE_Y0;
        xpos_missile <= xpos + X_CENTRE;
      end else if (state == vga_pkg::MISSILE_FLYING && missile_y >= vga_pkg::MISSILE_STEP) begin
        missile_y <= missile_y - vga_pkg::MISSILE_STEP;
      end
    end
  end

  assign missile_on = (state == vga_pkg::MISSILE_FLYING);

endmodule

`default_nettype wire

/* source/draw_background.sv */
/*
 * First colour stage: background fill with a one pixel border,
 * timing signals delayed by one register.
 */
`timescale 1ns/100ps
`default_nettype none

module draw_background #(
  parameter int H_ACTIVE = vga_pkg::H_ACTIVE_DEF,
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE_DEF
) (
  input  logic pclk,
  input  logic reset,
  vga_if.snk   in,
  vga_if.src   out
);

  localparam vga_pkg::count_t H_LAST = vga_pkg::count_t'(H_ACTIVE - 1);
  localparam vga_pkg::count_t V_LAST = vga_pkg::count_t'(V_ACTIVE - 1);

  vga_pkg::rgb_t rgb_nxt;
  logic          edge_px;

  assign edge_px = (in.hcount == '0) || (in.hcount == H_LAST) ||
                   (in.vcount == '0) || (in.vcount == V_LAST);

  always_comb begin
    if (in.hblnk || in.vblnk) begin
      // timing stage delivers black here
      rgb_nxt = in.rgb;
    end else if (edge_px) begin
      rgb_nxt = vga_pkg::BORDER_COLOR;
    end else begin
      rgb_nxt = vga_pkg::BG_COLOR;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      out.hsync <= 1'b0;
      out.vsync <= 1'b0;
      out.hblnk <= 1'b0;
      out.vblnk <= 1'b0;
    end else begin
      out.hsync <= in.hsync;
      out.vsync <= in.vsync;
      out.hblnk <= in.hblnk;
      out.vblnk <= in.vblnk;
    end
  end

  always_ff @(posedge pclk) begin
    out.hcount <= in.hcount;
    out.vcount <= in.vcount;
    out.rgb    <= rgb_nxt;
  end

endmodule

`default_nettype wire

/* source/draw_rect.sv */
/*
 * Player stage: solid rectangle on the player band at xpos,
 * other pixels pass through one register later.
 */
`timescale 1ns/100ps
`default_nettype none

module draw_rect #(
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE_DEF
) (
  input  logic            pclk,
  input  logic            reset,
  vga_if.snk              in,
  vga_if.src              out,
  input  vga_pkg::count_t xpos
);

  localparam vga_pkg::count_t ROW_TOP = vga_pkg::player_top(V_ACTIVE);
  localparam vga_pkg::count_t ROW_END = ROW_TOP + vga_pkg::PLAYER_H;

  vga_pkg::count_t x_end;
  logic            in_cols;
  logic            in_rows;
  vga_pkg::rgb_t   rgb_nxt;

  assign x_end   = xpos + vga_pkg::PLAYER_W;
  assign in_cols = (in.hcount >= xpos) && (in.hcount < x_end);
  // rows of the player band near the bottom of the active area
  assign in_rows = (in.vcount >= ROW_TOP) && (in.vcount < ROW_END);

  always_comb begin
    if (in_cols && in_rows) begin
      rgb_nxt = vga_pkg::PLAYER_COLOR;
    end else begin
      rgb_nxt = in.rgb;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      out.hsync <= 1'b0;
      out.vsync <= 1'b0;
      out.hblnk <= 1'b0;
      out.vblnk <= 1'b0;
    end else begin
      out.hsync <= in.hsync;
      out.vsync <= in.vsync;
      out.hblnk <= in.hblnk;
      out.vblnk <= in.vblnk;
    end
  end

  always_ff @(posedge pclk) begin
    out.hcount <= in.hcount;
    out.vcount <= in.vcount;
    out.rgb    <= rgb_nxt;
  end

endmodule

`default_nettype wire

/* source/draw_missile.sv */
/*
 * Missile stage: small box at the latched missile position while
 * the missile flies, drawn over the player.
 */
`timescale 1ns/100ps
`default_nettype none

module draw_missile (
  input  logic            pclk,
  input  logic            reset,
  vga_if.snk              in,
  vga_if.src              out,
  input  vga_pkg::count_t xpos_missile,
  input  vga_pkg::count_t missile_y,
  input  logic            missile_on
);

  vga_pkg::count_t x_end;
  vga_pkg::count_t y_end;
  logic            hit;
  vga_pkg::rgb_t   rgb_nxt;

  assign x_end = xpos_missile + vga_pkg::MISSILE_W;
  assign y_end = missile_y + vga_pkg::MISSILE_H;

  // missile box at the latched position while it flies
  assign hit = missile_on &&
               (in.hcount >= xpos_missile) && (in.hcount < x_end) &&
               (in.vcount >= missile_y) && (in.vcount < y_end);

  always_comb begin
    if (hit) begin
      rgb_nxt = vga_pkg::MISSILE_COLOR;
    end else begin
      rgb_nxt = in.rgb;
    end
  end

  always_ff @(posedge pclk) begin
    if (reset) begin
      out.hsync <= 1'b0;
      out.vsync <= 1'b0;
      out.hblnk <= 1'b0;
      out.vblnk <= 1'b0;
    end else begin
      out.hsync <= in.hsync;
      out.vsync <= in.vsync;
      out.hblnk <= in.hblnk;
      out.vblnk <= in.vblnk;
    end
  end

  always_ff @(posedge pclk) begin
    out.hcount <= in.hcount;
    out.vcount <= in.vcount;
    out.rgb    <= rgb_nxt;
  end

endmodule

`default_nettype wire

/* source/vga_game_top.sv */
/*
 * Top level of the game display: timing generator, game control and
 * the background, player and missile stages in a chain.
 */
`timescale 1ns/100ps
`default_nettype none

module vga_game_top #(
  parameter int H_ACTIVE = vga_pkg::H_ACTIVE_DEF,
  parameter int H_FRONT  = vga_pkg::H_FRONT_DEF,
  parameter int H_SYNC   = vga_pkg::H_SYNC_DEF,
  parameter int H_BACK   = vga_pkg::H_BACK_DEF,
  parameter int V_ACTIVE = vga_pkg::V_ACTIVE_DEF,
  parameter int V_FRONT  = vga_pkg::V_FRONT_DEF,
  parameter int V_SYNC   = vga_pkg::V_SYNC_DEF,
  parameter int V_BACK   = vga_pkg::V_BACK_DEF
) (
  input  logic       pclk,
  input  logic       reset,
  input  logic       left,
  input  logic       right,
  input  logic       fire,
  output logic       hs,
  output logic       vs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  vga_pkg::count_t xpos;
  vga_pkg::count_t xpos_missile;
  vga_pkg::count_t missile_y;
  logic            missile_on;

  vga_if tim_if ();
  vga_if bg_if ();
  vga_if rect_if ();
  vga_if out_if ();

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .pclk(pclk), .reset(reset), .tim(tim_if.src)
  );

  game_ctl #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_game_ctl (
    .pclk(pclk), .reset(reset),
    .left(left), .right(right), .fire(fire),
    .tim(tim_if.snk),
    .xpos(xpos), .xpos_missile(xpos_missile),
    .missile_y(missile_y), .missile_on(missile_on)
  );

  draw_background #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_background (
    .pclk(pclk), .reset(reset), .in(tim_if.snk), .out(bg_if.src)
  );

  draw_rect #(.V_ACTIVE(V_ACTIVE)) u_rect (
    .pclk(pclk), .reset(reset), .in(bg_if.snk), .out(rect_if.src), .xpos(xpos)
  );

  draw_missile u_missile (
    .pclk(pclk), .reset(reset), .in(rect_if.snk), .out(out_if.src),
    .xpos_missile(xpos_missile), .missile_y(missile_y), .missile_on(missile_on)
  );

  // three stages behind the timing counters
  assign hs = out_if.hsync;
  assign vs = out_if.vsync;
  assign r  = out_if.rgb[11:8];
  assign g  = out_if.rgb[7:4];
  assign b  = out_if.rgb[3:0];

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
/*
 * Testbench clock and reset source for the pixel clock domain.
 */
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic pclk,
  output logic reset
);

  initial begin
    pclk  = 1'b0;
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge pclk);
    reset <= 1'b0;
  end

  always #(PERIOD / 2) pclk = ~pclk;

endmodule

`default_nettype wire

/* tb/vga_game_props.sv */
/*
 * Assertions on the display outputs: quiet syncs in reset,
 * black colour in blanking, hsync pulse width.
 */
`timescale 1ns/100ps
`default_nettype none

module vga_game_props #(
  parameter int H_SYNC = 8
) (
  input logic       pclk,
  input logic       reset,
  input logic       hs,
  input logic       vs,
  input logic       hblnk,
  input logic       vblnk,
  input logic [3:0] r,
  input logic [3:0] g,
  input logic [3:0] b
);

  int hs_len;

  // consecutive cycles of hs high
  always_ff @(posedge pclk) begin
    if (reset || !hs) begin
      hs_len <= 0;
    end else begin
      hs_len <= hs_len + 1;
    end
  end

  reset_quiet: assert property (@(posedge pclk) (reset && $past(reset)) |-> (!hs && !vs))
    else $error("hs or vs active during reset");

  blank_black: assert property (@(posedge pclk) disable iff (reset)
    (hblnk || vblnk) |-> ({r, g, b} == 12'h000))
    else $error("colour not black during blanking");

  hs_width: assert property (@(posedge pclk) disable iff (reset) $fell(hs) |-> (hs_len == H_SYNC))
    else $error("hsync pulse width %0d, expected %0d", hs_len, H_SYNC);

endmodule

// blank flags taken from the last pipeline stage, aligned with the colour
bind vga_game_top vga_game_props #(.H_SYNC(H_SYNC)) u_props (
  .pclk(pclk), .reset(reset), .hs(hs), .vs(vs),
  .hblnk(out_if.hblnk), .vblnk(out_if.vblnk), .r(r), .g(g), .b(b)
);

`default_nettype wire

/* tb/vga_game_tb.sv */
/*
 * Testbench for the VGA game display: drives buttons from a pattern file,
 * decodes the picture from hs, vs and colour, checks it against a model.
 */
`timescale 1ns/100ps
`default_nettype none

module vga_game_tb;

  localparam int H_ACTIVE = 64;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT  = 2;
  localparam int V_SYNC   = 3;
  localparam int V_BACK   = 2;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int PLAYER_W = int'(vga_pkg::PLAYER_W);
  localparam int PLAYER_H = int'(vga_pkg::PLAYER_H);
  localparam int MIS_W    = int'(vga_pkg::MISSILE_W);
  localparam int MIS_H    = int'(vga_pkg::MISSILE_H);
  localparam int BAND_TOP = V_ACTIVE - PLAYER_H - 2;
  localparam int X_MAX    = H_ACTIVE - PLAYER_W;
  localparam int NO_MISSILE = 'h7ff;
  localparam int MAX_STEPS  = 32;

  logic pclk, reset, left, right, fire, hs, vs;
  logic [3:0] r, g, b;
  logic [11:0] pat_mem [0:6*MAX_STEPS-1];
  logic [11:0] pix, want;

  // game state shown in the frame on screen
  int model_x, model_mx, model_my;
  logic model_on;
  // picture decoder state
  int hpos, vpos, cyc, hs_fall_cyc, vs_fall_cyc, hs_high, vs_high;
  int meas_px, meas_mx, meas_my, frame_count;
  logic hs_d, vs_d, h_locked, v_locked, loaded;
  int errors, checks, n_steps, total_frames;

  clock_gen #(.PERIOD(100), .RESET_CYCLES(4)) u_clock (.pclk(pclk), .reset(reset));

  vga_game_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) dut (
    .pclk(pclk), .reset(reset), .left(left), .right(right), .fire(fire),
    .hs(hs), .vs(vs), .r(r), .g(g), .b(b)
  );

  task automatic check_value(string name, int expected, int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("Fail %s: expected %0d actual %0d", name, expected, actual);
    end
  endtask

  // missile over player over border over background
  function automatic logic [11:0] expected_pixel(int h, int v);
    if (h >= H_ACTIVE || v >= V_ACTIVE) return 12'h000;
    if (model_on && h >= model_mx && h < model_mx + MIS_W && v >= model_my &&
        v < model_my + MIS_H) return vga_pkg::MISSILE_COLOR;
    if (v >= BAND_TOP && v < BAND_TOP + PLAYER_H && h >= model_x && h < model_x + PLAYER_W)
      return vga_pkg::PLAYER_COLOR;
    if (h == 0 || h == H_ACTIVE - 1 || v == 0 || v == V_ACTIVE - 1) return vga_pkg::BORDER_COLOR;
    return vga_pkg::BG_COLOR;
  endfunction

  // one frame tick; the missile launches from the x shown before the move
  task automatic apply_tick(logic l, logic rt, logic f);
    if (model_on) begin
      if (model_my < int'(vga_pkg::MISSILE_STEP)) model_on = 1'b0;
      else model_my = model_my - int'(vga_pkg::MISSILE_STEP);
    end else if (f) begin
      model_on = 1'b1;
      model_my = BAND_TOP - MIS_H;
      model_mx = model_x + PLAYER_W / 2 - MIS_W / 2;
    end
    if (l && !rt) model_x = (model_x < 2) ? 0 : model_x - int'(vga_pkg::PLAYER_STEP);
    else if (rt && !l) model_x = (model_x + 2 > X_MAX) ? X_MAX : model_x + 2;
  endtask

  task automatic wait_frame_end();
    int seen;
    seen = frame_count;
    while (frame_count == seen) @(posedge pclk);
  endtask

  // decoder: hs and vs falling edges anchor the pixel and line positions
  always @(negedge pclk) begin
    cyc = cyc + 1;
    if (h_locked) begin
      hpos = hpos + 1;
      if (hpos == H_TOTAL) begin
        hpos = 0;
        vpos = (vpos + 1) % V_TOTAL;
      end
    end
    if (hs_d && !hs) begin
      if (h_locked) begin
        check_value("hs period cycles", H_TOTAL, cyc - hs_fall_cyc);
        check_value("pixel at hs fall", H_ACTIVE + H_FRONT + H_SYNC, hpos);
      end
      check_value("hs pulse cycles", H_SYNC, hs_high);
      hs_fall_cyc = cyc;
      h_locked = 1'b1;
      hpos = H_ACTIVE + H_FRONT + H_SYNC;
    end
    if (vs_d && !vs) begin
      if (v_locked) begin
        check_value("vs period cycles", FRAME_CYCLES, cyc - vs_fall_cyc);
        check_value("line at vs fall", V_ACTIVE + V_FRONT + V_SYNC, vpos);
      end
      check_value("vs pulse cycles", V_SYNC * H_TOTAL, vs_high);
      check_value("pixel at vs fall", 0, hpos);
      vs_fall_cyc = cyc;
      v_locked = 1'b1;
      vpos = V_ACTIVE + V_FRONT + V_SYNC;
    end
    hs_high = hs ? hs_high + 1 : 0;
    vs_high = vs ? vs_high + 1 : 0;
    hs_d = hs;
    vs_d = vs;
    if (v_locked) begin
      pix = {r, g, b};
      want = expected_pixel(hpos, vpos);
      checks++;
      if (pix != want) begin
        errors++;
        $display("Fail pixel %0d,%0d: expected %h actual %h", hpos, vpos, want, pix);
      end
      if (vpos == BAND_TOP && pix == vga_pkg::PLAYER_COLOR && meas_px < 0) meas_px = hpos;
      if (pix == vga_pkg::MISSILE_COLOR && meas_my < 0) begin
        meas_my = vpos;
        meas_mx = hpos;
      end
      // first blanking line, the frame tick has just been applied
      if (hpos == 0 && vpos == V_ACTIVE) begin
        check_value("player first column", model_x, meas_px);
        if (model_on) begin
          check_value("missile column", model_mx, meas_mx);
          check_value("missile row", model_my, meas_my);
        end else begin
          check_value("missile absent row", -1, meas_my);
        end
        meas_px = -1;
        meas_my = -1;
        meas_mx = -1;
        frame_count++;
      end
    end
  end

  initial begin
    int s;
    int f;
    int base;
    left = 1'b0;
    right = 1'b0;
    fire = 1'b0;
    {hs_d, vs_d, h_locked, v_locked, loaded, model_on} = '0;
    {cyc, hs_fall_cyc, vs_fall_cyc, hs_high, vs_high, frame_count} = '0;
    {errors, checks, n_steps, total_frames, model_mx, model_my} = '0;
    {hpos, vpos} = '0;
    meas_px = -1;
    meas_mx = -1;
    meas_my = -1;
    model_x = (H_ACTIVE - PLAYER_W) / 2;
    $readmemh("tb/vga_game_patterns.txt", pat_mem);
    while (n_steps < MAX_STEPS && pat_mem[n_steps * 6 + 3] != 12'h000) begin
      total_frames = total_frames + int'(pat_mem[n_steps * 6 + 3]);
      n_steps++;
    end
    if (n_steps == 0) begin
      errors++;
      $display("no pattern steps could be read from the pattern file");
    end
    loaded = 1'b1;
    wait_frame_end();
    for (s = 0; s < n_steps; s++) begin
      base = s * 6;
      left  <= pat_mem[base][0];
      right <= pat_mem[base + 1][0];
      fire  <= pat_mem[base + 2][0];
      for (f = 0; f < int'(pat_mem[base + 3]); f++) begin
        wait_frame_end();
        apply_tick(pat_mem[base][0], pat_mem[base + 1][0], pat_mem[base + 2][0]);
      end
      check_value($sformatf("step %0d player x", s), int'(pat_mem[base + 4]), model_x);
      check_value($sformatf("step %0d missile y", s), int'(pat_mem[base + 5]),
                  model_on ? model_my : NO_MISSILE);
    end
    // last state still has to be seen on screen
    wait_frame_end();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog, a few spare frames on top of the pattern length
  initial begin
    wait (loaded);
    #((total_frames + 4) * FRAME_CYCLES * 100);
    $display("watchdog: simulation did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/vga_pkg.sv
source/vga_if.sv
source/vga_timing.sv
source/game_ctl.sv
source/draw_background.sv
source/draw_rect.sv
source/draw_missile.sv
source/vga_game_top.sv
tb/clock_gen.sv
tb/vga_game_props.sv
tb/vga_game_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the simulation with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module vga_game_tb -o vga_game_sim \
  && ./obj_dir/vga_game_sim | tee /dev/stderr | grep -q "TESTS PASSED" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation not ok"; exit 1; }

/* tb/vga_game_patterns.txt */
// columns (hex): left right fire frames player_x missile_y
// missile_y 7ff means no missile on screen, a line with 0 frames ends the list
0 0 0 02 1c 7ff
0 1 0 03 22 7ff
1 1 0 02 22 7ff
1 0 0 14 00 7ff
0 1 0 1e 38 7ff
1 0 0 0e 1c 7ff
0 0 1 01 1c 027
0 0 1 03 1c 01b
1 0 0 02 18 013
0 0 0 06 18 7ff
0 0 1 01 18 027
0 0 0 02 18 01f
0 0 0 00 00 000
